//--- hdl/fpm_defs.svh
// fpm format constants: field widths, bias, special encodings and booth row count
`ifndef FPM_DEFS_SVH
`define FPM_DEFS_SVH

// ieee single precision fields
`define FP_EXP_W 8
`define FP_FRC_W 23

`define FP_BIAS 127
`define FP_EXP_MAX 255 // all-ones exponent

// canonical quiet nan
`define FP_QNAN 32'h7fc00000

// radix-8 digits needed for a 24-bit unsigned multiplier
`define BOOTH_ROWS 9

`define PROD_W 48

`endif

//--- hdl/fpm_pkg.sv
// fpm_pkg: vector and enum types shared by the floating-point multiplier
`include "fpm_defs.svh"

package fpm_pkg;

  // packed single precision word
  typedef logic [`FP_EXP_W+`FP_FRC_W:0] fp32_t;

  typedef logic [`FP_EXP_W-1:0] exp_t;  // biased exponent
  typedef logic [`FP_FRC_W-1:0] frc_t;  // stored fraction
  typedef logic [`FP_FRC_W:0]   sig_t;  // fraction plus hidden bit

  // full product, also one sign-extended partial product row
  typedef logic [`PROD_W-1:0] prod_t;

  typedef logic [2:0] rnd_t;

  // codes 5..7 are folded into rmm by the rounder
  typedef enum logic [2:0] {
    rne = 3'd0,  // nearest, ties to even
    rtz = 3'd1,  // toward zero
    rdn = 3'd2,  // toward -inf
    rup = 3'd3,  // toward +inf
    rmm = 3'd4   // nearest, ties away
  } rnd_mode_t;

endpackage

//--- hdl/fpm_operand_if.sv
// fpm_operand_if: decoded operand exponents, result sign and special-case flags
`timescale 1ns/1ps

interface fpm_operand_if;
  import fpm_pkg::*;

  logic sign_z;
  exp_t exp_x;
  exp_t exp_y;
  logic is_nan;   // nan operand or inf * 0
  logic is_inf;
  logic is_zero;  // zero or subnormal operand

  modport src (
    output sign_z, exp_x, exp_y, is_nan, is_inf, is_zero
  );

  modport dst (
    input sign_z, exp_x, exp_y, is_nan, is_inf, is_zero
  );

endinterface

//--- hdl/fp_unpack.sv
// fp_unpack: splits both operands into fields and classifies nan, infinity and zero
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fp_unpack (
  input  fpm_pkg::fp32_t fp_x,
  input  fpm_pkg::fp32_t fp_y,
  fpm_operand_if.src     ops,
  output fpm_pkg::frc_t  frc_x,
  output fpm_pkg::frc_t  frc_y
);
  import fpm_pkg::*;

  exp_t exp_x;
  exp_t exp_y;
  logic max_x, max_y;
  logic nan_x, nan_y;
  logic inf_x, inf_y;
  logic zero_x, zero_y;

  assign frc_x = fp_x[`FP_FRC_W-1:0];
  assign frc_y = fp_y[`FP_FRC_W-1:0];
  assign exp_x = fp_x[`FP_FRC_W +: `FP_EXP_W];
  assign exp_y = fp_y[`FP_FRC_W +: `FP_EXP_W];

  assign max_x = (exp_x == `FP_EXP_MAX);
  assign max_y = (exp_y == `FP_EXP_MAX);

  assign nan_x = max_x && (frc_x != '0);
  assign nan_y = max_y && (frc_y != '0);
  assign inf_x = max_x && (frc_x == '0);
  assign inf_y = max_y && (frc_y == '0);

  // subnormals flush to zero
  assign zero_x = (exp_x == '0);
  assign zero_y = (exp_y == '0);

  assign ops.sign_z  = fp_x[$bits(fp32_t)-1] ^ fp_y[$bits(fp32_t)-1];
  assign ops.exp_x   = exp_x;
  assign ops.exp_y   = exp_y;
  assign ops.is_nan  = nan_x || nan_y || (inf_x && zero_y) || (inf_y && zero_x);
  assign ops.is_inf  = inf_x || inf_y;
  assign ops.is_zero = zero_x || zero_y;

endmodule

//--- hdl/booth_radix8_encoder.sv
// booth_radix8_encoder: radix-8 booth partial products of the two significands
`timescale 1ns/1ps
`include "fpm_defs.svh"

module booth_radix8_encoder (
  input  fpm_pkg::frc_t  frc_x,
  input  fpm_pkg::frc_t  frc_y,
  output fpm_pkg::prod_t pp [0:`BOOTH_ROWS-1],
  output fpm_pkg::prod_t pp_neg
);
  import fpm_pkg::*;

  // multiplier bits with x[-1] = 0 at the bottom and zero padding on top
  localparam int XW = 3 * `BOOTH_ROWS + 1;
  // widest multiple is 4Y, 26 bits, plus one sign bit
  localparam int MW = $bits(sig_t) + 2;

  sig_t              sig_x;
  sig_t              sig_y;
  logic [MW-1:0]     y3;
  logic [XW-1:0]     x_ext;
  logic [`BOOTH_ROWS-1:0] neg;

  assign sig_x = {1'b1, frc_x};
  assign sig_y = {1'b1, frc_y};

  // hard multiple, formed once for all rows
  assign y3 = {1'b0, sig_y, 1'b0} + {2'b00, sig_y};

  assign x_ext = {{(XW - $bits(sig_t) - 1){1'b0}}, sig_x, 1'b0};

  for (genvar i = 0; i < `BOOTH_ROWS; i++) begin : g_row
    logic [3:0]    win;
    logic          neta, netb, netc;
    logic          sel_1y, sel_2y, sel_3y, sel_4y;
    logic [MW-1:0] mag;
    logic [MW:0]   row;

    assign win = x_ext[3*i +: 4];

    assign neta = win[0] ^ win[1];
    assign netb = win[1] ^ win[2];
    assign netc = win[2] ^ win[3];

    // digit magnitude decode
    assign sel_1y = neta & ~netc;
    assign sel_3y = neta & netc;
    assign sel_2y = ~neta & netb;
    assign sel_4y = ~neta & ~netb & netc;

    assign mag = ({MW{sel_1y}} & {2'b00, sig_y})
               | ({MW{sel_2y}} & {1'b0, sig_y, 1'b0})
               | ({MW{sel_3y}} & y3)
               | ({MW{sel_4y}} & {sig_y, 2'b00});

    assign neg[i] = win[3];
    assign row = {1'b0, mag} ^ {(MW+1){win[3]}}; // ones complement when negative

    // sign-extend, then move to weight 8^i
    assign pp[i] = prod_t'({{(`PROD_W - MW - 1){row[MW]}}, row}) << (3 * i);
  end

  // +1 of each negation sits at the row's lowest weight
  always_comb begin
    pp_neg = '0;
    for (int i = 0; i < `BOOTH_ROWS; i++) begin
      pp_neg[3*i] = neg[i];
    end
  end

endmodule

//--- hdl/csa_tree.sv
// csa_tree: 3:2 carry-save reduction of the booth rows and final carry-propagate add
`timescale 1ns/1ps
`include "fpm_defs.svh"

module csa_tree (
  input  fpm_pkg::prod_t pp [0:`BOOTH_ROWS-1],
  input  fpm_pkg::prod_t pp_neg,
  output fpm_pkg::prod_t product
);
  import fpm_pkg::*;

  // rows left after a number of 3:2 levels
  function automatic int rows_after(input int n0, input int lvl);
    int n;
    n = n0;
    for (int k = 0; k < lvl; k++) begin
      n = 2 * (n / 3) + n % 3;
    end
    return n;
  endfunction

  function automatic int levels_for(input int n0);
    int n;
    int l;
    n = n0;
    l = 0;
    while (n > 2) begin
      n = 2 * (n / 3) + n % 3;
      l++;
    end
    return l;
  endfunction

  localparam int N_ROWS = `BOOTH_ROWS + 1;  // booth rows plus correction word
  localparam int N_LVL  = levels_for(N_ROWS);

  prod_t lvl [0:N_LVL][0:N_ROWS-1];

  for (genvar r = 0; r < `BOOTH_ROWS; r++) begin : g_in
    assign lvl[0][r] = pp[r];
  end
  assign lvl[0][`BOOTH_ROWS] = pp_neg;

  for (genvar l = 0; l < N_LVL; l++) begin : g_lvl
    localparam int N   = rows_after(N_ROWS, l);
    localparam int G   = N / 3;
    localparam int NXT = 2 * G + N % 3;

    for (genvar g = 0; g < G; g++) begin : g_csa
      prod_t a, b, c;

      assign a = lvl[l][3*g];
      assign b = lvl[l][3*g+1];
      assign c = lvl[l][3*g+2];

      assign lvl[l+1][2*g]   = a ^ b ^ c;
      assign lvl[l+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;  // carry one weight up
    end

    // leftover rows skip this level
    for (genvar r = 0; r < N % 3; r++) begin : g_pass
      assign lvl[l+1][2*G+r] = lvl[l][3*G+r];
    end

    for (genvar r = NXT; r < N_ROWS; r++) begin : g_zero
      assign lvl[l+1][r] = '0;
    end
  end

  // wraps mod 2^48, the true product always fits
  assign product = lvl[N_LVL][0] + lvl[N_LVL][1];

endmodule

//--- hdl/normalize_round.sv
// normalize_round does one-bit normalization, guard/round/sticky and five-mode rounding
`timescale 1ns/1ps
`include "fpm_defs.svh"

module normalize_round (
  input  fpm_pkg::prod_t product,
  input  logic           sign_z,
  input  fpm_pkg::rnd_t  r_mode,
  output fpm_pkg::frc_t  frc_z,
  output logic           norm_n,
  output logic           norm_r
);
  import fpm_pkg::*;

  localparam int G_POS = `PROD_W - `FP_FRC_W - 2;  // guard bit index

  prod_t                shifted;
  sig_t                 sig;
  logic                 guard;
  logic                 rnd_bit;
  logic                 sticky;
  logic                 inexact;
  logic                 inc;
  rnd_mode_t            mode;
  logic [`FP_FRC_W+1:0] rounded;

  assign norm_n  = product[`PROD_W-1];
  assign shifted = norm_n ? product : product << 1;

  assign sig     = shifted[`PROD_W-1 -: $bits(sig_t)];
  assign guard   = shifted[G_POS];
  assign rnd_bit = shifted[G_POS-1];
  assign sticky  = |shifted[G_POS-2:0];
  assign inexact = guard | rnd_bit | sticky;

  // 5..7 behave as rmm
  assign mode = (r_mode > 3'd4) ? rmm : rnd_mode_t'(r_mode);

  always_comb begin
    case (mode)
      rne:     inc = guard & (rnd_bit | sticky | sig[0]);
      rtz:     inc = 1'b0;
      rdn:     inc = sign_z & inexact;
      rup:     inc = ~sign_z & inexact;
      default: inc = guard;
    endcase
  end

  assign rounded = {1'b0, sig} + {{(`FP_FRC_W+1){1'b0}}, inc};
  assign norm_r  = rounded[`FP_FRC_W+1];  // 1.111..1 rolled over to 10.000..0

  // fraction bits are all zero after a carry out
  assign frc_z = rounded[`FP_FRC_W-1:0];

endmodule

//--- hdl/exp_except_pack.sv
// exp_except_pack: result exponent, overflow/underflow, special results and output register
`timescale 1ns/1ps
`include "fpm_defs.svh"

module exp_except_pack (
  input  logic           clk,
  input  logic           rst_n,
  fpm_operand_if.dst     ops,
  input  fpm_pkg::frc_t  frc_z,
  input  logic           norm_n,
  input  logic           norm_r,
  output fpm_pkg::fp32_t fp_z,
  output logic           ovrf,
  output logic           udrf
);
  import fpm_pkg::*;

  // two spare bits cover -127 .. 385
  logic signed [`FP_EXP_W+1:0] exp_sum;
  exp_t   exp_z;
  logic   finite;
  logic   ovrf_d;
  logic   udrf_d;
  fp32_t  z_d;

  assign exp_sum = $signed({2'b00, ops.exp_x}) + $signed({2'b00, ops.exp_y}) - `FP_BIAS
                 + $signed({1'b0, norm_n}) + $signed({1'b0, norm_r});
  assign exp_z   = exp_sum[`FP_EXP_W-1:0];

  assign finite = ~(ops.is_nan | ops.is_inf | ops.is_zero);  // both finite, nonzero
  assign ovrf_d = finite && (exp_sum >= `FP_EXP_MAX);
  assign udrf_d = finite && (exp_sum <= 0);

  always_comb begin
    if (ops.is_nan) begin
      z_d = `FP_QNAN;
    end else if (ops.is_inf || ovrf_d) begin
      z_d = {ops.sign_z, {`FP_EXP_W{1'b1}}, {`FP_FRC_W{1'b0}}};
    end else if (ops.is_zero || udrf_d) begin
      z_d = {ops.sign_z, {(`FP_EXP_W + `FP_FRC_W){1'b0}}};  // signed zero
    end else begin
      z_d = {ops.sign_z, exp_z, frc_z};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fp_z <= '0;
      ovrf <= 1'b0;
      udrf <= 1'b0;
    end else begin
      fp_z <= z_d;
      ovrf <= ovrf_d;
      udrf <= udrf_d;
    end
  end

endmodule

//--- hdl/fpm_top.sv
// fpm_top: single precision multiplier with one output register stage
`timescale 1ns/1ps
`include "fpm_defs.svh"

module fpm_top (
  input  logic           clk,
  input  logic           rst_n,
  input  fpm_pkg::rnd_t  r_mode,
  input  fpm_pkg::fp32_t fp_x,
  input  fpm_pkg::fp32_t fp_y,
  output fpm_pkg::fp32_t fp_z,
  output logic           ovrf,
  output logic           udrf
);
  import fpm_pkg::*;

  frc_t  frc_x;
  frc_t  frc_y;
  frc_t  frc_z;
  prod_t pp [0:`BOOTH_ROWS-1];
  prod_t pp_neg;
  prod_t product;
  logic  norm_n;
  logic  norm_r;

  fpm_operand_if ops ();

  fp_unpack u_unpack (
    .fp_x  (fp_x),
    .fp_y  (fp_y),
    .ops   (ops.src),
    .frc_x (frc_x),
    .frc_y (frc_y)
  );

  booth_radix8_encoder u_booth (
    .frc_x  (frc_x),
    .frc_y  (frc_y),
    .pp     (pp),
    .pp_neg (pp_neg)
  );

  csa_tree u_tree (
    .pp      (pp),
    .pp_neg  (pp_neg),
    .product (product)
  );

  normalize_round u_round (
    .product (product),
    .sign_z  (ops.sign_z),
    .r_mode  (r_mode),
    .frc_z   (frc_z),
    .norm_n  (norm_n),
    .norm_r  (norm_r)
  );

  exp_except_pack u_pack (
    .clk    (clk),
    .rst_n  (rst_n),
    .ops    (ops.dst),
    .frc_z  (frc_z),
    .norm_n (norm_n),
    .norm_r (norm_r),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

endmodule

//--- sim/fpm_model.svh
// fpm_model: reference single precision multiply with the project's rounding and exception rules
`ifndef FPM_MODEL_SVH
`define FPM_MODEL_SVH

`include "fpm_defs.svh"

function automatic void model_mul(input fp32_t x, input fp32_t y, input rnd_t mode,
                                  output fp32_t z, output logic ov, output logic un);
  logic [7:0]  ex, ey;
  logic [22:0] fx, fy;
  logic        sz;
  logic [47:0] p;
  logic [23:0] sig;
  logic        g, r, s, inc;
  logic [24:0] rs;
  logic        nn, nr;
  logic        nan, inf, zero, fin;
  int          e;

  ex = x[30:23];
  ey = y[30:23];
  fx = x[22:0];
  fy = y[22:0];
  sz = x[31] ^ y[31];

  p   = {24'd0, 1'b1, fx} * {24'd0, 1'b1, fy};  // exact, never wraps
  nn  = p[47];
  p   = nn ? p : p << 1;
  sig = p[47:24];
  g   = p[23];
  r   = p[22];
  s   = |p[21:0];

  case (mode)
    3'd0:    inc = g & (r | s | sig[0]);
    3'd1:    inc = 1'b0;
    3'd2:    inc = sz & (g | r | s);
    3'd3:    inc = !sz & (g | r | s);
    default: inc = g;  // 4..7 ties away
  endcase

  rs = {1'b0, sig} + {24'd0, inc};
  nr = rs[24];
  e  = int'(ex) + int'(ey) - `FP_BIAS + int'(nn) + int'(nr);

  nan  = (ex == 8'hff && fx != 0) || (ey == 8'hff && fy != 0)
       || (ex == 8'hff && ey == 0) || (ey == 8'hff && ex == 0);
  inf  = (ex == 8'hff) || (ey == 8'hff);
  zero = (ex == 0) || (ey == 0);
  fin  = !(nan || inf || zero);
  ov   = fin && (e >= 255);
  un   = fin && (e <= 0);

  if (nan) begin
    z = `FP_QNAN;
  end else if (inf || ov) begin
    z = {sz, 8'hff, 23'd0};
  end else if (zero || un) begin
    z = {sz, 31'd0};
  end else begin
    z = {sz, e[7:0], (nr ? rs[23:1] : rs[22:0])};
  end
endfunction

`endif

//--- sim/fpm_tb.sv
// fpm_tb runs directed and random tests of the floating-point multiplier against a reference model
`timescale 1ns/1ps

module fpm_tb;
  import fpm_pkg::*;

  `include "fpm_model.svh"

  localparam int SEED       = 79;
  localparam int RESET_CYC  = 8;
  localparam int N_MODE_VEC = 150;
  localparam int N_STREAM   = 200;
  localparam int MAX_CYCLES = 2000;  // about 1450 cycles of tests plus margin

  logic  clk;
  logic  rst_n;
  rnd_t  r_mode;
  fp32_t fp_x, fp_y, fp_z;
  logic  ovrf, udrf;

  int    seed;
  int    cycles = 0;
  int    pass_cnt = 0;
  int    fail_cnt = 0;
  int    test_err = 0;
  int    test_ops = 0;
  logic  pend_valid = 1'b0;  // an op whose result is due at the next negedge
  fp32_t pend_z;
  logic  pend_ov, pend_un;

  fpm_top uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .r_mode (r_mode),
    .fp_x   (fp_x),
    .fp_y   (fp_y),
    .fp_z   (fp_z),
    .ovrf   (ovrf),
    .udrf   (udrf)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  task automatic check_word(input string name, input fp32_t exp_v, input fp32_t act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s expected %h actual %h", name, exp_v, act_v);
      fail_cnt++;
      test_err++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("ERR %s expected %h actual %h", name, exp_v, act_v);
      fail_cnt++;
      test_err++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_pending();
    if (pend_valid) begin
      check_word("fp_z", pend_z, fp_z);
      check_flag("ovrf", pend_ov, ovrf);
      check_flag("udrf", pend_un, udrf);
    end
  endtask

  // drives one new op per cycle and checks the one before it
  task automatic issue_expect(input fp32_t x, input fp32_t y, input rnd_t mode,
                              input fp32_t z, input logic ov, input logic un);
    @(posedge clk);
    fp_x   <= x;
    fp_y   <= y;
    r_mode <= mode;
    @(negedge clk);
    check_pending();
    pend_valid = 1'b1;
    pend_z     = z;
    pend_ov    = ov;
    pend_un    = un;
    test_ops++;
  endtask

  task automatic issue_model(input fp32_t x, input fp32_t y, input rnd_t mode);
    fp32_t z;
    logic  ov, un;
    model_mul(x, y, mode, z, ov, un);
    issue_expect(x, y, mode, z, ov, un);
  endtask

  task automatic finish_test(input string name);
    @(posedge clk);
    @(negedge clk);
    check_pending();
    pend_valid = 1'b0;
    $display("%-12s %4d ops  %0d errors", name, test_ops, test_err);
    test_ops = 0;
    test_err = 0;
  endtask

  function automatic fp32_t rand_finite();
    logic [31:0] r;
    exp_t        e;
    r = $random(seed);
    e = exp_t'(64 + ($unsigned($random(seed)) % 127));  // 64..190
    return {r[31], e, r[22:0]};
  endfunction

  task automatic reset_test();
    for (int i = 0; i < RESET_CYC; i++) begin
      @(posedge clk);
      if (i == RESET_CYC - 1) rst_n <= 1'b1;  // still sampled low on this edge
      @(negedge clk);
      check_word("fp_z", '0, fp_z);
      check_flag("ovrf", 1'b0, ovrf);
      check_flag("udrf", 1'b0, udrf);
      test_ops++;
    end
    $display("%-12s %4d ops  %0d errors", "reset", test_ops, test_err);
    test_ops = 0;
    test_err = 0;
  endtask

  task automatic directed_test();
    issue_expect(32'h3fc00000, 32'h40000000, rne, 32'h40400000, 1'b0, 1'b0);
    issue_expect(32'hc0400000, 32'h3e800000, rne, 32'hbf400000, 1'b0, 1'b0);
    issue_expect(32'h40e00000, 32'h40a00000, rne, 32'h420c0000, 1'b0, 1'b0);  // 7 * 5
    issue_expect(32'h3f800000, 32'hbf800000, rne, 32'hbf800000, 1'b0, 1'b0);
    // exact results take no increment in the directed modes
    issue_expect(32'hc0400000, 32'h3e800000, rdn, 32'hbf400000, 1'b0, 1'b0);
    issue_expect(32'h3fc00000, 32'h40000000, rup, 32'h40400000, 1'b0, 1'b0);
    // ties at half an ulp
    issue_expect(32'h3fc00006, 32'h3fc00000, rne, 32'h40100004, 1'b0, 1'b0);  // even stays
    issue_expect(32'h3fc00002, 32'h3fc00000, rne, 32'h40100002, 1'b0, 1'b0);  // odd goes up
    issue_expect(32'h3fc00006, 32'h3fc00000, rmm, 32'h40100005, 1'b0, 1'b0);
    for (int m = 5; m < 8; m++) begin
      issue_expect(32'h3fc00006, 32'h3fc00000, rnd_t'(m), 32'h40100005, 1'b0, 1'b0);
    end
    finish_test("directed");
  endtask

  task automatic mode_test(input rnd_t mode);
    logic [31:0] r;
    r = $random(seed);
    // significand product of 2^47 - 1 carries out when rounded up
    // sign is negative only for rdn so that rdn and rup round up too
    issue_model({r[0], 8'd130, 23'h21e58f},
                {r[0] ^ (mode == rdn), 8'd120, 23'h4a6691}, mode);
    for (int i = 1; i < N_MODE_VEC; i++) begin
      issue_model(rand_finite(), rand_finite(), mode);
    end
    finish_test($sformatf("mode %0d", mode));
  endtask

  task automatic range_test();
    issue_expect({1'b1, 8'd200, 23'h0}, {1'b0, 8'd190, 23'h123456}, rne,
                 32'hff800000, 1'b1, 1'b0);
    issue_expect({1'b0, 8'd191, 23'h0}, {1'b0, 8'd191, 23'h0}, rne, 32'h7f800000, 1'b1, 1'b0);
    issue_expect({1'b0, 8'd190, 23'h0}, {1'b0, 8'd191, 23'h0}, rne, 32'h7f000000, 1'b0, 1'b0);
    issue_expect({1'b0, 8'd60, 23'h0}, {1'b1, 8'd60, 23'h0}, rne, 32'h80000000, 1'b0, 1'b1);
    issue_expect({1'b0, 8'd63, 23'h0}, {1'b0, 8'd64, 23'h0}, rne, 32'h00000000, 1'b0, 1'b1);
    issue_expect({1'b0, 8'd64, 23'h0}, {1'b0, 8'd64, 23'h0}, rne, 32'h00800000, 1'b0, 1'b0);
    finish_test("range");
  endtask

  task automatic special_test();
    issue_expect(32'h7f800001, 32'h3f800000, rne, `FP_QNAN, 1'b0, 1'b0);
    issue_expect(32'hffc00000, 32'h40400000, rtz, `FP_QNAN, 1'b0, 1'b0);
    issue_expect(32'h7f800000, 32'h00000000, rne, `FP_QNAN, 1'b0, 1'b0);
    issue_expect(32'h80000000, 32'hff800000, rup, `FP_QNAN, 1'b0, 1'b0);
    issue_expect(32'h7f800000, 32'hbf800000, rne, 32'hff800000, 1'b0, 1'b0);
    issue_expect(32'hff800000, 32'hff800000, rne, 32'h7f800000, 1'b0, 1'b0);
    issue_expect(32'h80000000, 32'h40000000, rne, 32'h80000000, 1'b0, 1'b0);
    issue_expect(32'h00000001, 32'hc0000000, rdn, 32'h80000000, 1'b0, 1'b0);  // subnormal
    issue_expect(32'h00400000, 32'h3f800000, rne, 32'h00000000, 1'b0, 1'b0);
    finish_test("special");
  endtask

  task automatic stream_test();
    logic [31:0] x, y, m;
    for (int i = 0; i < N_STREAM; i++) begin
      x = $random(seed);
      y = $random(seed);
      m = $random(seed);
      issue_model(x, y, m[2:0]);
    end
    finish_test("stream");
  endtask

  initial begin
    seed = SEED;
    rst_n  <= 1'b0;
    fp_x   <= 32'h3f800000;  // nonzero inputs so a missing reset would show
    fp_y   <= 32'h40000000;
    r_mode <= '0;
    reset_test();
    directed_test();
    for (int m = 0; m < 8; m++) begin
      mode_test(rnd_t'(m));
    end
    range_test();
    special_test();
    stream_test();
    $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
+incdir+sim
hdl/fpm_pkg.sv
hdl/fpm_operand_if.sv
hdl/fp_unpack.sv
hdl/booth_radix8_encoder.sv
hdl/csa_tree.sv
hdl/normalize_round.sv
hdl/exp_except_pack.sv
hdl/fpm_top.sv
sim/fpm_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fpm_tb -f verilog.f

out=$(./obj_dir/Vfpm_tb)
echo "$out"

if grep -qx '>>> PASS' <<< "$out"; then
  exit 0
fi
exit 1
